// ==== ram_pkg.sv ====
/* Shared definitions for the latency dual-port RAM
   Memory sizes, the port operation encoding and the port structs */
package ram_pkg;

  //////////////////////////////////////////////////////////////////////
  // Memory geometry
  //////////////////////////////////////////////////////////////////////

  // Width of one stored word
  localparam int DATA_WIDTH = 8;

  // Number of words in the array
  localparam int MEM_DEPTH = 16;

  // Address width follows from the depth
  localparam int ADDR_WIDTH = $clog2(MEM_DEPTH);

  //////////////////////////////////////////////////////////////////////
  // Port operation and payload types
  //////////////////////////////////////////////////////////////////////

  // One operation per port per cycle
  // OP_IDLE must stay at zero so that a cleared pipe stage means no command
  typedef enum logic [1:0] {
    OP_IDLE  = 2'd0,
    OP_READ  = 2'd1,
    OP_WRITE = 2'd2
  } ram_op_e;

  // Command as seen at a port input and along its write delay line
  typedef struct packed {
    ram_op_e                 op;
    logic [ADDR_WIDTH-1:0]   addr;
    logic [DATA_WIDTH-1:0]   wdata;
  } port_cmd_t;

  // Read response as it leaves the core and travels the read delay line
  // The data field only has meaning while valid is high
  typedef struct packed {
    logic                    valid;
    logic [DATA_WIDTH-1:0]   data;
  } rd_resp_t;

endpackage

// ==== pipe_delay.sv ====
/* Generic delay line for any packed type
   Shifts the input through STAGES cleared registers, or passes it straight on */
`timescale 1ns/1ps

module pipe_delay #(
  parameter type T      = logic,
  parameter int  STAGES = 1
) (
  input  logic clka,
  input  logic i_rst_n,
  input  T     i_d,
  output T     o_q
);

  generate
    if (STAGES == 0)
    begin : g_bypass
      // No registers at all, so the output follows the input in the same cycle
      // A latency of one at the top level lands here
      assign o_q = i_d;
    end
    else
    begin : g_shift
      // Stage 0 takes the input and the last stage drives the output
      T stage_q [STAGES];

      always_ff @(posedge clka or negedge i_rst_n)
      begin
        if (!i_rst_n)
        begin
          // A cleared stage reads as an idle command or an invalid response
          for (int i = 0; i < STAGES; i++)
          begin
            stage_q[i] <= '0;
          end
        end
        else
        begin
          stage_q[0] <= i_d;
          // Every older stage moves one step toward the output
          for (int i = 1; i < STAGES; i++)
          begin
            stage_q[i] <= stage_q[i-1];
          end
        end
      end

      assign o_q = stage_q[STAGES-1];
    end
  endgenerate

endmodule

// ==== write_arbiter.sv ====
/* Write collision resolver between the two delayed RAM ports
   Port A always wins and a colliding port B write is dropped and flagged */
`timescale 1ns/1ps

module write_arbiter (
  input  ram_pkg::port_cmd_t i_cmd_a,
  input  ram_pkg::port_cmd_t i_cmd_b,
  output ram_pkg::port_cmd_t o_cmd_a,
  output ram_pkg::port_cmd_t o_cmd_b,
  output logic               o_wr_drop_b
);

  import ram_pkg::*;

  // High when both ports write the same word at the same core edge
  logic wr_collide;

  //////////////////////////////////////////////////////////////////////
  // Collision detect
  //////////////////////////////////////////////////////////////////////

  // Reads never collide since the core returns old data on both ports
  assign wr_collide = (i_cmd_a.op == OP_WRITE) &&
                      (i_cmd_b.op == OP_WRITE) &&
                      (i_cmd_a.addr == i_cmd_b.addr);

  // Port A is never touched
  assign o_cmd_a = i_cmd_a;

  always_comb
  begin
    o_cmd_b = i_cmd_b;
    // Only the operation is cleared so the core sees an idle slot on port B
    if (wr_collide)
    begin
      o_cmd_b.op = OP_IDLE;
    end
  end

  // The flag is seen in the cycle before the edge that would have written
  assign o_wr_drop_b = wr_collide;

endmodule

// ==== dp_ram_core.sv ====
/* Dual-port memory array with read-first ports
   Registers one read response per port and applies writes in A then B order */
`timescale 1ns/1ps

module dp_ram_core (
  input  logic               clka,
  input  logic               i_rst_n,
  input  ram_pkg::port_cmd_t i_cmd_a,
  input  ram_pkg::port_cmd_t i_cmd_b,
  output ram_pkg::rd_resp_t  o_resp_a,
  output ram_pkg::rd_resp_t  o_resp_b
);

  import ram_pkg::*;

  // Port index 0 is A and index 1 is B
  localparam int NUM_PORTS = 2;

  // The storage itself has no reset
  logic [DATA_WIDTH-1:0] mem [MEM_DEPTH];

  // Both commands gathered so each port runs through the same loop
  port_cmd_t cmd [NUM_PORTS];

  // Read response registers per port
  logic                  rd_valid_q [NUM_PORTS];
  logic [DATA_WIDTH-1:0] rd_data_q  [NUM_PORTS];

  assign cmd[0] = i_cmd_a;
  assign cmd[1] = i_cmd_b;

  //////////////////////////////////////////////////////////////////////
  // Read side
  //////////////////////////////////////////////////////////////////////

  // Valid is control state and clears on reset
  always_ff @(posedge clka or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      for (int p = 0; p < NUM_PORTS; p++)
      begin
        rd_valid_q[p] <= 1'b0;
      end
    end
    else
    begin
      // One cycle pulse for every read that reaches the core
      for (int p = 0; p < NUM_PORTS; p++)
      begin
        rd_valid_q[p] <= (cmd[p].op == OP_READ);
      end
    end
  end

  // Data is captured only on a read and holds otherwise
  // The array value sampled here is the one from before this edge's writes
  always_ff @(posedge clka)
  begin
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      if (cmd[p].op == OP_READ)
      begin
        rd_data_q[p] <= mem[cmd[p].addr];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Write side
  //////////////////////////////////////////////////////////////////////

  // Port A goes first and port B after it
  // The arbiter has already removed any B write that hits A's address
  always_ff @(posedge clka)
  begin
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      if (cmd[p].op == OP_WRITE)
      begin
        mem[cmd[p].addr] <= cmd[p].wdata;
      end
    end
  end

  // Pack the registered fields back into the response structs
  assign o_resp_a = '{valid: rd_valid_q[0], data: rd_data_q[0]};
  assign o_resp_b = '{valid: rd_valid_q[1], data: rd_data_q[1]};

endmodule

// ==== ram_latency_top.sv ====
/* Dual-port RAM with separate write and read latency on each port
   Delays commands, resolves write collisions and delays read responses */
`timescale 1ns/1ps

module ram_latency_top #(
  parameter int WR_LAT_A = 1,
  parameter int RD_LAT_A = 1,
  parameter int WR_LAT_B = 1,
  parameter int RD_LAT_B = 1
) (
  input  logic               clka,
  input  logic               i_rst_n,
  input  ram_pkg::port_cmd_t i_cmd_a,
  input  ram_pkg::port_cmd_t i_cmd_b,
  output ram_pkg::rd_resp_t  o_resp_a,
  output ram_pkg::rd_resp_t  o_resp_b,
  output logic               o_wr_drop_b
);

  import ram_pkg::*;

  // The core itself adds one register on each path
  // So a latency of one needs no extra stage and maps to a bypass
  localparam int WR_STG_A = WR_LAT_A - 1;
  localparam int RD_STG_A = RD_LAT_A - 1;
  localparam int WR_STG_B = WR_LAT_B - 1;
  localparam int RD_STG_B = RD_LAT_B - 1;

  // Commands after the write delay lines
  port_cmd_t cmd_dly_a;
  port_cmd_t cmd_dly_b;

  // Commands after collision handling, as seen by the array
  port_cmd_t cmd_arb_a;
  port_cmd_t cmd_arb_b;

  // Responses straight out of the core
  rd_resp_t  core_resp_a;
  rd_resp_t  core_resp_b;

  //////////////////////////////////////////////////////////////////////
  // Write latency
  //////////////////////////////////////////////////////////////////////

  pipe_delay #(.T(port_cmd_t), .STAGES(WR_STG_A)) wr_dly_a_i (
    .clka    (clka),
    .i_rst_n (i_rst_n),
    .i_d     (i_cmd_a),
    .o_q     (cmd_dly_a)
  );

  pipe_delay #(.T(port_cmd_t), .STAGES(WR_STG_B)) wr_dly_b_i (
    .clka    (clka),
    .i_rst_n (i_rst_n),
    .i_d     (i_cmd_b),
    .o_q     (cmd_dly_b)
  );

  // Collisions are judged at the core edge, not at the port inputs
  write_arbiter write_arbiter_i (
    .i_cmd_a     (cmd_dly_a),
    .i_cmd_b     (cmd_dly_b),
    .o_cmd_a     (cmd_arb_a),
    .o_cmd_b     (cmd_arb_b),
    .o_wr_drop_b (o_wr_drop_b)
  );

  dp_ram_core dp_ram_core_i (
    .clka     (clka),
    .i_rst_n  (i_rst_n),
    .i_cmd_a  (cmd_arb_a),
    .i_cmd_b  (cmd_arb_b),
    .o_resp_a (core_resp_a),
    .o_resp_b (core_resp_b)
  );

  //////////////////////////////////////////////////////////////////////
  // Read latency
  //////////////////////////////////////////////////////////////////////

  pipe_delay #(.T(rd_resp_t), .STAGES(RD_STG_A)) rd_dly_a_i (
    .clka    (clka),
    .i_rst_n (i_rst_n),
    .i_d     (core_resp_a),
    .o_q     (o_resp_a)
  );

  pipe_delay #(.T(rd_resp_t), .STAGES(RD_STG_B)) rd_dly_b_i (
    .clka    (clka),
    .i_rst_n (i_rst_n),
    .i_d     (core_resp_b),
    .o_q     (o_resp_b)
  );

endmodule

// ==== tb_ram_latency.sv ====
/* Self-checking testbench for the latency dual-port RAM
   Drives both ports, predicts every response with a shadow model and compares */
`timescale 1ns/1ps

module tb_ram_latency;

  import ram_pkg::*;

  // Port index 0 is A and index 1 is B
  localparam int WR_LAT [2] = '{1, 3};
  localparam int RD_LAT [2] = '{1, 2};

  localparam int RESET_CYCLES = 5;
  localparam int IDLE_CYCLES  = 10;
  localparam int RAND_CYCLES  = 200;
  localparam int RING         = 16;

  // Stimulus cycles of all tests and the idle time spent waiting for pipes to empty
  localparam int NUM_CMDS   = IDLE_CYCLES + 4 * MEM_DEPTH + 4 + RAND_CYCLES;
  localparam int NUM_DRAINS = 7;
  localparam int DRAIN_MAX  = WR_LAT[1] + RD_LAT[1] + 2;
  localparam int CYCLE_LIMIT = RESET_CYCLES + NUM_CMDS + NUM_DRAINS * DRAIN_MAX + 50;

  logic      clka;
  logic      i_rst_n;
  port_cmd_t i_cmd_a;
  port_cmd_t i_cmd_b;
  rd_resp_t  o_resp_a;
  rd_resp_t  o_resp_b;
  logic      o_wr_drop_b;

  // Counts rising edges so it equals the number of the last one
  int cycle = 0;

  // Shadow memory and commands waiting for their core edge
  logic [DATA_WIDTH-1:0] shadow [MEM_DEPTH];
  port_cmd_t             pend   [2][RING];
  // Expected read data per port with the cycle it must be seen in
  int                    due_q  [2][$];
  logic [DATA_WIDTH-1:0] data_q [2][$];
  logic                  exp_drop;
  int                    quiet_edge;

  string test_name = "reset";
  int    errors = 0;
  int    test_errs_start = 0;
  int    tests_run = 0;
  int    tests_failed = 0;
  int    drop_count = 0;
  int    drop_before;

  ram_latency_top #(
    .WR_LAT_A (WR_LAT[0]),
    .RD_LAT_A (RD_LAT[0]),
    .WR_LAT_B (WR_LAT[1]),
    .RD_LAT_B (RD_LAT[1])
  ) ram_latency_top_i (
    .clka        (clka),
    .i_rst_n     (i_rst_n),
    .i_cmd_a     (i_cmd_a),
    .i_cmd_b     (i_cmd_b),
    .o_resp_a    (o_resp_a),
    .o_resp_b    (o_resp_b),
    .o_wr_drop_b (o_wr_drop_b)
  );

  initial
  begin
    clka = 1'b0;
    forever #4 clka = ~clka;
  end

  always @(posedge clka)
  begin
    cycle <= cycle + 1;
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // At core edge e both reads see the old contents, then A writes, then B unless it hits A
  function automatic void model_step(input int e);
    port_cmd_t ca;
    port_cmd_t cb;
    logic      coll;
    ca = pend[0][e % RING];
    cb = pend[1][e % RING];
    pend[0][e % RING] = '0;
    pend[1][e % RING] = '0;
    coll = (ca.op == OP_WRITE) && (cb.op == OP_WRITE) && (ca.addr == cb.addr);
    if (ca.op == OP_READ)
    begin
      due_q[0].push_back(e + RD_LAT[0] - 1);
      data_q[0].push_back(shadow[ca.addr]);
    end
    if (cb.op == OP_READ)
    begin
      due_q[1].push_back(e + RD_LAT[1] - 1);
      data_q[1].push_back(shadow[cb.addr]);
    end
    if (ca.op == OP_WRITE)
      shadow[ca.addr] = ca.wdata;
    if (cb.op == OP_WRITE && !coll)
      shadow[cb.addr] = cb.wdata;
    exp_drop = coll;
  endfunction

  task automatic check_value(input string what, input logic [DATA_WIDTH-1:0] exp_val,
                             input logic [DATA_WIDTH-1:0] act_val);
    if (act_val !== exp_val)
    begin
      $display("** Error %s: expected 0x%02h, actual 0x%02h", what, exp_val, act_val);
      errors++;
    end
  endtask

  // Compares one port's output against the head of its expected queue
  task automatic compare_port(input int p, input rd_resp_t resp);
    logic  due_now;
    string pname;
    pname   = (p == 0) ? "A" : "B";
    due_now = (due_q[p].size() != 0) && (due_q[p][0] == cycle);
    if (resp.valid && !due_now)
    begin
      $display("Port %s gave a read response at cycle %0d with no read due (test %s)",
               pname, cycle, test_name);
      errors++;
    end
    else if (!resp.valid && due_now)
    begin
      $display("Port %s missed the read response due at cycle %0d (test %s)",
               pname, cycle, test_name);
      errors++;
      void'(due_q[p].pop_front());
      void'(data_q[p].pop_front());
    end
    else if (resp.valid)
    begin
      check_value({test_name, "/port ", pname}, data_q[p][0], resp.data);
      void'(due_q[p].pop_front());
      void'(data_q[p].pop_front());
    end
  endtask

  // A command seen now is sampled at the next edge and reaches the core WL-1 edges later
  task automatic record_cmd(input int p, input port_cmd_t cmd);
    if (cmd.op != OP_IDLE)
    begin
      pend[p][(cycle + WR_LAT[p]) % RING] = cmd;
      if (cycle + WR_LAT[p] + RD_LAT[p] > quiet_edge)
        quiet_edge = cycle + WR_LAT[p] + RD_LAT[p];
    end
  endtask

  // The compare process runs on the falling edge where every output is settled
  always @(negedge clka)
  begin
    if (!i_rst_n)
    begin
      for (int i = 0; i < RING; i++)
      begin
        pend[0][i] = '0;
        pend[1][i] = '0;
      end
      quiet_edge = 0;
      exp_drop = 1'b0;
    end
    else
    begin
      compare_port(0, o_resp_a);
      compare_port(1, o_resp_b);
      record_cmd(0, i_cmd_a);
      record_cmd(1, i_cmd_b);
      // The drop flag already shows the collision of the coming edge
      model_step(cycle + 1);
      check_value({test_name, "/drop"}, DATA_WIDTH'(exp_drop), DATA_WIDTH'(o_wr_drop_b));
      if (o_wr_drop_b)
        drop_count++;
    end
  end

  always @(posedge clka)
  begin
    if (cycle >= CYCLE_LIMIT)
    begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  function automatic port_cmd_t make_cmd(input ram_op_e op, input int addr, input int data);
    port_cmd_t c;
    c.op    = op;
    c.addr  = ADDR_WIDTH'(addr);
    c.wdata = DATA_WIDTH'(data);
    return c;
  endfunction

  function automatic port_cmd_t rand_cmd();
    logic [31:0] r;
    port_cmd_t   c;
    r       = $urandom();
    c.op    = ram_op_e'(r[1:0] % 2'd3);
    c.addr  = r[2+:ADDR_WIDTH];
    c.wdata = r[8+:DATA_WIDTH];
    return c;
  endfunction

  task automatic issue_cmds(input port_cmd_t a, input port_cmd_t b);
    @(posedge clka);
    i_cmd_a <= a;
    i_cmd_b <= b;
  endtask

  // Idles both ports until every predicted response has arrived
  task automatic drain_pipes();
    do
      issue_cmds('0, '0);
    while (due_q[0].size() != 0 || due_q[1].size() != 0 || cycle <= quiet_edge);
  endtask

  task automatic finish_test();
    int errs;
    errs = errors - test_errs_start;
    tests_run++;
    if (errs != 0)
      tests_failed++;
    $display("Test %s finished with %0d mismatches", test_name, errs);
    test_errs_start = errors;
  endtask

  initial
  begin
    void'($urandom(32'h323d));
    i_rst_n  = 1'b0;
    i_cmd_a  = '0;
    i_cmd_b  = '0;
    repeat (RESET_CYCLES) @(posedge clka);
    i_rst_n <= 1'b1;

    // Nothing issued, so any valid or drop pulse is an error
    test_name = "reset_idle";
    repeat (IDLE_CYCLES) issue_cmds('0, '0);
    drain_pipes();
    finish_test();

    test_name = "port_a_loop";
    for (int k = 0; k < MEM_DEPTH; k++)
      issue_cmds(make_cmd(OP_WRITE, k, k * 13 + 5), '0);
    for (int k = 0; k < MEM_DEPTH; k++)
      issue_cmds(make_cmd(OP_READ, k, 0), '0);
    drain_pipes();
    finish_test();

    // Each read starts with B's write but lands first, so it returns the old word
    test_name = "b_write_a_read";
    for (int k = 0; k < MEM_DEPTH; k++)
      issue_cmds(make_cmd(OP_READ, k, 0), make_cmd(OP_WRITE, k, 8'ha0 ^ k));
    drain_pipes();
    for (int k = 0; k < MEM_DEPTH; k++)
      issue_cmds(make_cmd(OP_READ, k, 0), '0);
    drain_pipes();
    finish_test();

    // B leaves two cycles early so both writes meet at the same core edge
    test_name = "collision";
    drop_before = drop_count;
    issue_cmds('0, make_cmd(OP_WRITE, 5, 8'h3c));
    issue_cmds('0, '0);
    issue_cmds(make_cmd(OP_WRITE, 5, 8'hc3), '0);
    drain_pipes();
    issue_cmds(make_cmd(OP_READ, 5, 0), '0);
    drain_pipes();
    check_value(test_name, DATA_WIDTH'(1), DATA_WIDTH'(drop_count - drop_before));
    finish_test();

    test_name = "random";
    for (int k = 0; k < RAND_CYCLES; k++)
      issue_cmds(rand_cmd(), rand_cmd());
    drain_pipes();
    finish_test();

    $display("Summary: %0d tests run, %0d failed, %0d mismatches",
             tests_run, tests_failed, errors);
    if (errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// ==== sim.f ====
ram_pkg.sv
pipe_delay.sv
write_arbiter.sv
dp_ram_core.sv
ram_latency_top.sv
tb_ram_latency.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_ram_latency
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run and look for the pass message"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
